/* source/rsrc_pkg.sv */
// shared definitions for the uplink radio data source
// - output word and RB size constants
// - request, carrier configuration and AXI-Stream beat types
// - RB size function used when a packet is loaded
package rsrc_pkg;

  // --------------------------------------------------------------------
  // sizes and codes
  // --------------------------------------------------------------------
  // bytes per 64-bit output word
  localparam int DATA_BYTES = 8;
  // bytes per RB with no compression
  localparam int RB_UNCOMP_BYTES = 48;
  // udCompMeth code for block floating point
  localparam logic [3:0] COMP_BFP = 4'd1;

  typedef logic [8:0] rb_idx_t;
  typedef logic [7:0] rb_cnt_t;
  // offset or count of bytes inside one RB, max 48
  typedef logic [5:0] byte_ofs_t;
  typedef logic [2:0] cc_id_t;

  // --------------------------------------------------------------------
  // structured signals
  // --------------------------------------------------------------------
  // one byte per carrier, laid out like udCompHdr
  typedef struct packed {
    logic [3:0] iq_width;
    logic [3:0] comp_meth;
  } cc_cfg_t;

  // beamformer style request, 20 bits
  typedef struct packed {
    rb_idx_t rb_start;
    rb_cnt_t num_rb;
    cc_id_t  cc;
  } rb_req_t;

  typedef struct packed {
    logic [63:0] tdata;
    logic [7:0]  tkeep;
    logic        tvalid;
    logic        tlast;
  } axis_beat_t;

  // bytes per RB: 3*iqwidth+1 for BFP (exponent byte), 48 otherwise
  function automatic byte_ofs_t rb_bytes(cc_cfg_t cfg);
    if (cfg.comp_meth == COMP_BFP) begin
      return byte_ofs_t'({2'b00, cfg.iq_width} * 6'd3 + 6'd1);
    end
    return byte_ofs_t'(RB_UNCOMP_BYTES);
  endfunction

endpackage

/* source/req_queue.sv */
// request queue for the radio source
// - input register stage for the request pulse
// - circular store with wrapping read and write pointers
// - fill count and head-of-queue output
module req_queue import rsrc_pkg::*; #(
  parameter int QUEUE_DEPTH = 8
) (
  input  logic    clk,
  input  logic    resetn,
  input  rb_req_t i_req,
  input  logic    i_req_valid,
  input  logic    i_pop,
  output rb_req_t o_head,
  output logic    o_req_pending
);

  localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
  localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

  rb_req_t    req_q;
  logic       req_valid_q;
  rb_req_t    mem [QUEUE_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic       push;

  // a full queue only takes a request when the head leaves on the same edge
  assign push = req_valid_q && ((count != CNT_W'(QUEUE_DEPTH)) || i_pop);

  // --------------------------------------------------------------------
  // capture stage
  // --------------------------------------------------------------------
  always_ff @(posedge clk) begin
    req_q <= i_req;
    if (!resetn) begin
      req_valid_q <= 1'b0;
    end else begin
      req_valid_q <= i_req_valid;
    end
  end

  // storage
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= req_q;
    end
  end

  // --------------------------------------------------------------------
  // pointers and fill count
  // --------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!resetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (i_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // push and pop together leave the count alone
      if (push && !i_pop) begin
        count <= count + 1'b1;
      end else if (!push && i_pop) begin
        count <= count - 1'b1;
      end
    end
  end

  assign o_head        = mem[rd_ptr];
  assign o_req_pending = (count != '0);

endmodule

/* source/rb_seq_fsm.sv */
// packet sequencer for the radio source
// - IDLE/LOAD/PREP/SEND/LAST state machine
// - start, step and emit pulses for the byte counter and word builder
// - queue pop at packet end and next-cycle tvalid level
module rb_seq_fsm (
  input  logic clk,
  input  logic resetn,
  input  logic i_req_pending,
  input  logic i_rb_end,
  input  logic i_pkt_end,
  input  logic i_tready,
  output logic o_start,
  output logic o_step,
  output logic o_emit,
  output logic o_last_beat,
  output logic o_pop,
  output logic o_tvalid
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_LOAD,
    ST_PREP,
    ST_SEND,
    ST_LAST
  } seq_state_t;

  seq_state_t state;
  seq_state_t state_nxt;
  logic       word_last;

  // the closing word is the one that ends the final RB
  assign word_last = i_rb_end && i_pkt_end;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state <= ST_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // --------------------------------------------------------------------
  // next state and pulses
  // --------------------------------------------------------------------
  always_comb begin
    state_nxt   = state;
    o_start     = 1'b0;
    o_step      = 1'b0;
    o_emit      = 1'b0;
    o_last_beat = 1'b0;
    o_pop       = 1'b0;
    o_tvalid    = 1'b0;
    case (state)
      ST_IDLE: begin
        if (i_req_pending) begin
          state_nxt = ST_LOAD;
        end
      end
      // counter latches the head request
      ST_LOAD: begin
        o_start   = 1'b1;
        state_nxt = ST_PREP;
      end
      // first word into the empty output register
      ST_PREP: begin
        o_emit      = 1'b1;
        o_step      = 1'b1;
        o_last_beat = word_last;
        o_tvalid    = 1'b1;
        state_nxt   = word_last ? ST_LAST : ST_SEND;
      end
      // one word per accepted beat, frozen under back-pressure
      ST_SEND: begin
        o_tvalid = 1'b1;
        if (i_tready) begin
          o_emit      = 1'b1;
          o_step      = 1'b1;
          o_last_beat = word_last;
          if (word_last) begin
            state_nxt = ST_LAST;
          end
        end
      end
      // tlast beat on the bus, tvalid drops once it is taken
      ST_LAST: begin
        if (i_tready) begin
          o_pop     = 1'b1;
          state_nxt = ST_IDLE;
        end
      end
      default: state_nxt = ST_IDLE;
    endcase
  end

endmodule

/* source/rb_byte_counter.sv */
// byte position tracking inside the current packet
// - latches RB start, RB count and RB size on start
// - registered bytes-left scheme, one step per output word
// - RB end and packet end flags for the sequencer
module rb_byte_counter import rsrc_pkg::*; #(
  parameter int NUM_CC = 8
) (
  input  logic                   clk,
  input  logic                   resetn,
  input  logic                   i_start,
  input  logic                   i_step,
  input  rb_req_t                i_head,
  input  cc_cfg_t [NUM_CC-1:0]   i_cc_cfg,
  output byte_ofs_t              o_byte_ofs,
  output byte_ofs_t              o_bytes_left,
  output rb_idx_t                o_rb_ord,
  output logic                   o_rb_end,
  output logic                   o_pkt_end
);

  rb_idx_t   rb_start_q;
  rb_cnt_t   num_rb_m1_q;
  byte_ofs_t rb_size_q;
  byte_ofs_t byte_ofs;
  byte_ofs_t bytes_left;
  rb_cnt_t   rb_cnt;
  // bytes of the next RB that spill into a boundary word
  byte_ofs_t spill;

  assign spill = byte_ofs_t'(DATA_BYTES) - bytes_left;

  // packet constants, only read between start and pop
  always_ff @(posedge clk) begin
    if (i_start) begin
      rb_start_q  <= i_head.rb_start;
      num_rb_m1_q <= i_head.num_rb - 1'b1;
      rb_size_q   <= rb_bytes(i_cc_cfg[i_head.cc]);
    end
  end

  // --------------------------------------------------------------------
  // position update
  // --------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!resetn) begin
      byte_ofs   <= '0;
      bytes_left <= '0;
      rb_cnt     <= '0;
    end else if (i_start) begin
      byte_ofs   <= '0;
      bytes_left <= rb_bytes(i_cc_cfg[i_head.cc]);
      rb_cnt     <= '0;
    end else if (i_step) begin
      if (o_rb_end) begin
        // word closes this RB, carry on in the next one past the spill
        byte_ofs   <= spill;
        bytes_left <= rb_size_q - spill;
        rb_cnt     <= rb_cnt + 1'b1;
      end else begin
        byte_ofs   <= byte_ofs + byte_ofs_t'(DATA_BYTES);
        bytes_left <= bytes_left - byte_ofs_t'(DATA_BYTES);
      end
    end
  end

  assign o_byte_ofs   = byte_ofs;
  assign o_bytes_left = bytes_left;
  assign o_rb_ord     = rb_start_q + rb_idx_t'(rb_cnt);
  assign o_rb_end     = (bytes_left <= byte_ofs_t'(DATA_BYTES));
  assign o_pkt_end    = o_rb_end && (rb_cnt == num_rb_m1_q);

endmodule

/* source/rb_word_builder.sv */
// output word builder for the radio source
// - pattern bytes per lane from CC, RB order and byte offset
// - splice of two RBs on a boundary word
// - AXI-Stream output register with tkeep on the last beat
module rb_word_builder import rsrc_pkg::*; #(
  parameter int NUM_CC = 8
) (
  input  logic       clk,
  input  logic       resetn,
  input  logic       i_emit,
  input  logic       i_last_beat,
  input  logic       i_tvalid,
  input  logic       i_tready,
  input  cc_id_t     i_cc,
  input  byte_ofs_t  i_byte_ofs,
  input  byte_ofs_t  i_bytes_left,
  input  rb_idx_t    i_rb_ord,
  output axis_beat_t o_axis
);

  axis_beat_t             beat_q;
  logic                   out_free;
  cc_id_t                 cc_tag;
  rb_idx_t                rb_next;
  logic [63:0]            word_d;
  logic [DATA_BYTES-1:0]  in_rb;

  // byte o of an RB is half of the lane {cc, rb, o/2 mod 16}
  function automatic logic [7:0] pat_byte(cc_id_t cc, rb_idx_t rb, byte_ofs_t ofs);
    logic [15:0] lane;
    lane = {cc, rb, ofs[4:1]};
    return ofs[0] ? lane[15:8] : lane[7:0];
  endfunction

  // carriers beyond the configured count are tagged as CC 0
  assign cc_tag   = (int'(i_cc) < NUM_CC) ? i_cc : '0;
  assign rb_next  = i_rb_ord + 1'b1;
  // register may load when empty or when the current beat is taken
  assign out_free = !beat_q.tvalid || i_tready;

  // --------------------------------------------------------------------
  // lane select
  // --------------------------------------------------------------------
  always_comb begin
    for (int x = 0; x < DATA_BYTES; x++) begin
      in_rb[x] = (byte_ofs_t'(x) < i_bytes_left);
      if (in_rb[x]) begin
        word_d[8*x +: 8] = pat_byte(cc_tag, i_rb_ord, i_byte_ofs + byte_ofs_t'(x));
      end else begin
        // rest of the word starts the following RB at offset 0
        word_d[8*x +: 8] = pat_byte(cc_tag, rb_next, byte_ofs_t'(x) - i_bytes_left);
      end
    end
  end

  // --------------------------------------------------------------------
  // output register
  // --------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!resetn) begin
      beat_q.tvalid <= 1'b0;
      beat_q.tlast  <= 1'b0;
    end else if (out_free) begin
      beat_q.tvalid <= i_tvalid;
      beat_q.tlast  <= i_emit && i_last_beat;
    end
  end

  always_ff @(posedge clk) begin
    if (out_free && i_emit) begin
      beat_q.tdata <= word_d;
      // last word keeps only the bytes of the final RB
      beat_q.tkeep <= i_last_beat ? in_rb : '1;
    end
  end

  assign o_axis = beat_q;

endmodule

/* source/radio_source_top.sv */
// top level of the uplink radio data source
// - request queue, packet sequencer, byte counter, word builder
// - sets carrier count and queue depth for the hierarchy
module radio_source_top import rsrc_pkg::*; #(
  parameter int NUM_CC      = 8,
  parameter int QUEUE_DEPTH = 8
) (
  input  logic                 clk,
  input  logic                 resetn,
  input  rb_req_t              i_req,
  input  logic                 i_req_valid,
  input  cc_cfg_t [NUM_CC-1:0] i_cc_cfg,
  input  logic                 i_tready,
  output axis_beat_t           o_axis
);

  // --------------------------------------------------------------------
  // interconnect
  // --------------------------------------------------------------------
  rb_req_t   head;
  logic      req_pending;
  logic      pop;
  logic      start;
  logic      step;
  logic      emit;
  logic      last_beat;
  logic      tvalid_nxt;
  logic      rb_end;
  logic      pkt_end;
  byte_ofs_t byte_ofs;
  byte_ofs_t bytes_left;
  rb_idx_t   rb_ord;

  req_queue #(
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) u_req_queue (
    .clk           (clk),
    .resetn        (resetn),
    .i_req         (i_req),
    .i_req_valid   (i_req_valid),
    .i_pop         (pop),
    .o_head        (head),
    .o_req_pending (req_pending)
  );

  rb_seq_fsm u_rb_seq_fsm (
    .clk           (clk),
    .resetn        (resetn),
    .i_req_pending (req_pending),
    .i_rb_end      (rb_end),
    .i_pkt_end     (pkt_end),
    .i_tready      (i_tready),
    .o_start       (start),
    .o_step        (step),
    .o_emit        (emit),
    .o_last_beat   (last_beat),
    .o_pop         (pop),
    .o_tvalid      (tvalid_nxt)
  );

  rb_byte_counter #(
    .NUM_CC (NUM_CC)
  ) u_rb_byte_counter (
    .clk          (clk),
    .resetn       (resetn),
    .i_start      (start),
    .i_step       (step),
    .i_head       (head),
    .i_cc_cfg     (i_cc_cfg),
    .o_byte_ofs   (byte_ofs),
    .o_bytes_left (bytes_left),
    .o_rb_ord     (rb_ord),
    .o_rb_end     (rb_end),
    .o_pkt_end    (pkt_end)
  );

  // head stays put until pop, so its CC is valid for the whole packet
  rb_word_builder #(
    .NUM_CC (NUM_CC)
  ) u_rb_word_builder (
    .clk          (clk),
    .resetn       (resetn),
    .i_emit       (emit),
    .i_last_beat  (last_beat),
    .i_tvalid     (tvalid_nxt),
    .i_tready     (i_tready),
    .i_cc         (head.cc),
    .i_byte_ofs   (byte_ofs),
    .i_bytes_left (bytes_left),
    .i_rb_ord     (rb_ord),
    .o_axis       (o_axis)
  );

endmodule

/* include/tb_ref_model.svh */
// reference model for the radio source testbench
// - RB size and packet length from a carrier configuration
// - expected pattern byte at any position of a packet
// - expected tkeep per beat
// types come from rsrc_pkg, imported where this file is included
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// 3*iqwidth+1 under BFP, 48 otherwise
function automatic int ref_rb_size(cc_cfg_t cfg);
  if (cfg.comp_meth == 4'd1) begin
    return 3 * int'(cfg.iq_width) + 1;
  end
  return 48;
endfunction

function automatic int ref_pkt_len(rb_req_t req, cc_cfg_t cfg);
  return int'(req.num_rb) * ref_rb_size(cfg);
endfunction

function automatic int ref_num_beats(int len);
  return (len + 7) / 8;
endfunction

// byte idx of the packet, counted from the low byte of the first word
function automatic logic [7:0] ref_byte(rb_req_t req, cc_cfg_t cfg, int idx);
  int          ofs;
  logic [8:0]  rb;
  logic [15:0] lane;
  ofs  = idx % ref_rb_size(cfg);
  rb   = req.rb_start + 9'(idx / ref_rb_size(cfg));
  lane = {req.cc, rb, 4'((ofs / 2) % 16)};
  return (ofs % 2 == 1) ? lane[15:8] : lane[7:0];
endfunction

// full keep except for a short final word
function automatic logic [7:0] ref_tkeep(int len, int beat);
  if ((beat == ref_num_beats(len) - 1) && (len % 8 != 0)) begin
    return 8'((1 << (len % 8)) - 1);
  end
  return 8'hff;
endfunction

`endif

/* test/tb_radio_source.sv */
// testbench for the uplink radio data source
// - clock, reset, request stimulus and random tready back-pressure
// - compare process checking each accepted beat against the reference model
// - AXI-Stream hold and tlast gap checks, closing error summary
module tb_radio_source import rsrc_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_CC      = 8;
  localparam int QUEUE_DEPTH = 8;
  localparam int WAIT_LIMIT  = 20000;

  `include "tb_ref_model.svh"

  logic                 clk;
  logic                 resetn;
  rb_req_t              req;
  logic                 req_valid;
  cc_cfg_t [NUM_CC-1:0] cc_cfg;
  logic                 tready;
  axis_beat_t           axis;
  logic                 bp_en;

  // requests sent and not yet fully seen on the output
  rb_req_t    exp_q[$];
  int         data_errs;
  int         proto_errs;
  int         timeout_errs;
  int         sent_cnt;
  int         pkts_done;
  int         last_pkt_beats;
  logic [7:0] last_pkt_keep;

  radio_source_top #(
    .NUM_CC      (NUM_CC),
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) i_dut (
    .clk         (clk),
    .resetn      (resetn),
    .i_req       (req),
    .i_req_valid (req_valid),
    .i_cc_cfg    (cc_cfg),
    .i_tready    (tready),
    .o_axis      (axis)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // tready toggles at random while back-pressure is on, 1 in 4 cycles low
  initial begin
    forever begin
      @(posedge clk);
      #1;
      tready = bp_en ? (($urandom % 4) != 0) : 1'b1;
    end
  end

  // --------------------------------------------------------------------
  // reference word and byte mask
  // --------------------------------------------------------------------
  // bytes past the packet length stay zero
  function automatic logic [63:0] expected_word(rb_req_t r, cc_cfg_t cfg, int beat);
    logic [63:0] w;
    int          idx;
    w = '0;
    for (int x = 0; x < DATA_BYTES; x++) begin
      idx = beat * DATA_BYTES + x;
      if (idx < ref_pkt_len(r, cfg)) begin
        w[8*x +: 8] = ref_byte(r, cfg, idx);
      end
    end
    return w;
  endfunction

  function automatic logic [63:0] keep_mask(logic [7:0] keep);
    logic [63:0] m;
    for (int x = 0; x < DATA_BYTES; x++) begin
      m[8*x +: 8] = {8{keep[x]}};
    end
    return m;
  endfunction

  // --------------------------------------------------------------------
  // compare process, samples at the falling edge
  // --------------------------------------------------------------------
  initial begin : compare_proc
    int          beat_idx;
    int          len;
    rb_req_t     cur;
    cc_cfg_t     cfg;
    logic [7:0]  keep_exp;
    logic [63:0] word_exp;
    logic        stalled;
    logic        last_taken;
    axis_beat_t  held;
    beat_idx   = 0;
    stalled    = 1'b0;
    last_taken = 1'b0;
    held       = '0;
    forever begin
      @(negedge clk);
      if (resetn) begin
        // a stalled beat must come back unchanged
        if (stalled) begin
          assert (axis == held) else begin
            $display("FAIL %0t: output changed while tready was low", $time);
            proto_errs++;
          end
        end
        if (last_taken) begin
          assert (!axis.tvalid) else begin
            $display("FAIL %0t: tvalid high right after a tlast beat", $time);
            proto_errs++;
          end
        end
        if (exp_q.size() == 0) begin
          assert (!axis.tvalid && !axis.tlast) else begin
            $display("FAIL %0t: tvalid or tlast high with no request queued", $time);
            proto_errs++;
          end
        end
        stalled    = 1'b0;
        last_taken = 1'b0;
        if (axis.tvalid && tready && exp_q.size() != 0) begin
          cur      = exp_q[0];
          cfg      = cc_cfg[cur.cc];
          len      = ref_pkt_len(cur, cfg);
          keep_exp = ref_tkeep(len, beat_idx);
          word_exp = expected_word(cur, cfg, beat_idx);
          assert (axis.tkeep == keep_exp) else begin
            $display("FAIL %0t: cc %0d rb %0d beat %0d tkeep %h, expected %h",
                     $time, cur.cc, cur.rb_start, beat_idx, axis.tkeep, keep_exp);
            data_errs++;
          end
          assert ((axis.tdata & keep_mask(keep_exp)) == word_exp) else begin
            $display("FAIL %0t: cc %0d rb %0d beat %0d tdata %h, expected %h",
                     $time, cur.cc, cur.rb_start, beat_idx, axis.tdata, word_exp);
            data_errs++;
          end
          assert (axis.tlast == (beat_idx == ref_num_beats(len) - 1)) else begin
            $display("FAIL %0t: cc %0d rb %0d beat %0d tlast %b, packet of %0d beats",
                     $time, cur.cc, cur.rb_start, beat_idx, axis.tlast, ref_num_beats(len));
            data_errs++;
          end
          last_taken = axis.tlast;
          // packet closes on tlast or on the expected beat count
          if (axis.tlast || beat_idx == ref_num_beats(len) - 1) begin
            last_pkt_beats = beat_idx + 1;
            last_pkt_keep  = axis.tkeep;
            void'(exp_q.pop_front());
            pkts_done++;
            beat_idx = 0;
          end else begin
            beat_idx++;
          end
        end else if (axis.tvalid && !tready) begin
          stalled = 1'b1;
          held    = axis;
        end
      end
    end
  end

  // --------------------------------------------------------------------
  // stimulus tasks
  // --------------------------------------------------------------------
  task automatic push_req(rb_req_t r);
    @(posedge clk);
    #1;
    req       = r;
    req_valid = 1'b1;
    exp_q.push_back(r);
    sent_cnt++;
  endtask

  task automatic release_req();
    @(posedge clk);
    #1;
    req_valid = 1'b0;
  endtask

  // n requests on consecutive cycles with random fields
  task automatic send_burst(int n);
    rb_req_t r;
    for (int i = 0; i < n; i++) begin
      r.cc       = cc_id_t'($urandom % NUM_CC);
      r.rb_start = rb_idx_t'($urandom % 512);
      r.num_rb   = rb_cnt_t'(1 + $urandom % 12);
      push_req(r);
    end
    release_req();
  endtask

  // keep the DUT queue from overflowing
  task automatic wait_room(int n);
    int cyc;
    for (cyc = 0; cyc < WAIT_LIMIT; cyc++) begin
      if (exp_q.size() + n <= QUEUE_DEPTH - 1) break;
      @(posedge clk);
    end
    if (cyc == WAIT_LIMIT) begin
      $display("timeout: queued packets did not drain to make room for %0d requests", n);
      timeout_errs++;
    end
  endtask

  task automatic wait_drain();
    int cyc;
    for (cyc = 0; cyc < WAIT_LIMIT; cyc++) begin
      if (exp_q.size() == 0) break;
      @(posedge clk);
    end
    if (cyc == WAIT_LIMIT) begin
      $display("timeout: %0d packets still missing from the output", exp_q.size());
      timeout_errs++;
    end
    repeat (3) @(posedge clk);
  endtask

  task automatic check_last_packet(int beats, logic [7:0] keep);
    assert (last_pkt_beats == beats && last_pkt_keep == keep) else begin
      $display("FAIL %0t: packet had %0d beats and last tkeep %h, expected %0d and %h",
               $time, last_pkt_beats, last_pkt_keep, beats, keep);
      data_errs++;
    end
  endtask

  // --------------------------------------------------------------------
  // main sequence
  // --------------------------------------------------------------------
  initial begin : main_proc
    rb_req_t r;
    int      n;
    void'($urandom(48598));
    resetn         = 1'b0;
    req            = '0;
    req_valid      = 1'b0;
    tready         = 1'b1;
    bp_en          = 1'b0;
    data_errs      = 0;
    proto_errs     = 0;
    timeout_errs   = 0;
    sent_cnt       = 0;
    pkts_done      = 0;
    last_pkt_beats = 0;
    last_pkt_keep  = '0;
    // cc 0 uncompressed, cc 1 BFP with 9-bit IQ, the rest random
    cc_cfg[0].iq_width  = 4'd0;
    cc_cfg[0].comp_meth = 4'd0;
    cc_cfg[1].iq_width  = 4'd9;
    cc_cfg[1].comp_meth = COMP_BFP;
    for (int c = 2; c < NUM_CC; c++) begin
      cc_cfg[c].iq_width  = 4'(3 + $urandom % 13);
      cc_cfg[c].comp_meth = ($urandom % 2) ? COMP_BFP : 4'd0;
    end
    repeat (10) @(posedge clk);
    #1;
    resetn = 1'b1;
    // idle output with nothing queued
    repeat (20) @(posedge clk);
    // one uncompressed RB, six full words
    r.cc       = 3'd0;
    r.rb_start = 9'd5;
    r.num_rb   = 8'd1;
    push_req(r);
    release_req();
    wait_drain();
    check_last_packet(6, 8'hff);
    // 5 RBs of 28 bytes, 140 bytes end 4 bytes into beat 18
    r.cc       = 3'd1;
    r.rb_start = 9'd100;
    r.num_rb   = 8'd5;
    push_req(r);
    release_req();
    wait_drain();
    check_last_packet(18, 8'h0f);
    // random bursts, tready held high
    for (int i = 0; i < 10; i++) begin
      n = 1 + $urandom % 4;
      wait_room(n);
      send_burst(n);
    end
    wait_drain();
    // same again under random back-pressure
    bp_en = 1'b1;
    for (int i = 0; i < 10; i++) begin
      n = 1 + $urandom % 4;
      wait_room(n);
      send_burst(n);
      repeat ($urandom % 20) @(posedge clk);
    end
    wait_drain();
    bp_en = 1'b0;
    repeat (5) @(posedge clk);
    $display("errors: data %0d, protocol %0d, timeout %0d; packets %0d of %0d",
             data_errs, proto_errs, timeout_errs, pkts_done, sent_cnt);
    if (data_errs + proto_errs + timeout_errs == 0 && pkts_done == sent_cnt) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

/* filelist.f */
+incdir+include
source/rsrc_pkg.sv
source/req_queue.sv
source/rb_seq_fsm.sv
source/rb_byte_counter.sv
source/rb_word_builder.sv
source/radio_source_top.sv
test/tb_radio_source.sv

/* run.sh */
#!/bin/sh
# build and run the radio source testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f filelist.f \
  --top-module tb_radio_source -o sim_radio_source || { echo "build error"; exit 1; }
out=$(./obj_dir/sim_radio_source)
echo "$out"
echo "$out" | grep -qx "Testbench passed" && exit 0 || exit 1
